// ==== rtc_access_top.f ====
design/rtc_access_pkg.sv
design/seq_bus_if.sv
design/access_seq.sv
design/bus_arbiter.sv
design/rtc_access_top.sv
tb/rtc_access_props.sv
tb/tb_rtc_access.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rtc_access
FILELIST  = rtc_access_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_rtc_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rtc_access;

  import rtc_access_pkg::*;

  // Run sizing
  localparam int n_rand         = 8;
  localparam int n_pairs        = 3;
  localparam int n_accesses     = 2 * n_rand + 2 + 2 * n_pairs + 2;
  localparam int timeout_cycles = n_accesses * (access_cycles + 8) + 200;
  localparam int lone_latency   = 2 + access_cycles + 1;
  localparam int mem_depth      = 1 << addr_w;
  localparam logic [31:0] lfsr_seed = 32'hc4dd_d0f5;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;

  logic                clk;
  logic                arst_n;
  logic                rd_start;
  logic [addr_w-1:0]   rd_addr;
  logic [sh_idx_w-1:0] rd_sh_idx;
  logic                rd_load;
  logic                rd_done;
  logic                wr_start;
  logic [addr_w-1:0]   wr_addr;
  logic [data_w-1:0]   wr_wdata;
  logic                wr_done;
  logic [sh_idx_w-1:0] sh_idx;
  logic [data_w-1:0]   sh_data;
  logic                bus_cs;
  logic                bus_we;
  logic [addr_w-1:0]   bus_addr;
  logic [data_w-1:0]   bus_wdata;
  logic [data_w-1:0]   bus_rdata;

  // Device contents and the reference copies
  logic [data_w-1:0] dev_mem [mem_depth];
  logic [data_w-1:0] ref_mem [mem_depth];
  logic [data_w-1:0] ref_sh  [sh_count];
  logic [addr_w-1:0] wr_addrs [n_rand];

  logic [31:0] lfsr_state;
  logic        cmp_en;
  int          err_count;
  int          check_count;
  int          cmp_errs = 0;
  int          cmp_checks = 0;
  int          cycle_count;

  rtc_access_top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_start  (rd_start),
    .rd_addr   (rd_addr),
    .rd_sh_idx (rd_sh_idx),
    .rd_load   (rd_load),
    .rd_done   (rd_done),
    .wr_start  (wr_start),
    .wr_addr   (wr_addr),
    .wr_wdata  (wr_wdata),
    .wr_done   (wr_done),
    .sh_idx    (sh_idx),
    .sh_data   (sh_data),
    .bus_cs    (bus_cs),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers: fill pattern, LFSR, reference model
  ////////////////////////////////////////////////////////////////////////////

  // Power-up content, every address bit matters
  function automatic logic [data_w-1:0] fill_byte(input logic [addr_w-1:0] a);
    return (a ^ 8'h5c) + {a[0], a[7:1]};
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ lfsr_taps;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [addr_w-1:0] rand_addr();
    return addr_w'(rand_bits(addr_w));
  endfunction

  function automatic logic [data_w-1:0] rand_byte();
    return data_w'(rand_bits(data_w));
  endfunction

  function automatic logic [sh_idx_w-1:0] rand_idx();
    return sh_idx_w'(rand_bits(sh_idx_w));
  endfunction

  // Address whose current content differs from avoid
  function automatic logic [addr_w-1:0] addr_not_holding(input logic [data_w-1:0] avoid);
    logic [addr_w-1:0] a;
    a = rand_addr();
    while (ref_mem[a] == avoid) begin
      a = rand_addr();
    end
    return a;
  endfunction

  function automatic void ref_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    ref_mem[a] = d;
  endfunction

  // Only a read with load touches the shadow copy
  function automatic void ref_read(input logic [addr_w-1:0] a,
                                   input logic [sh_idx_w-1:0] idx, input logic load);
    if (load) begin
      ref_sh[idx] = ref_mem[a];
    end
  endfunction

  function automatic logic [data_w-1:0] ref_shadow(input logic [sh_idx_w-1:0] idx);
    return ref_sh[idx];
  endfunction

  function automatic int total_errors();
    return err_count + cmp_errs + u_dut.u_arb.u_props.fail_count;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Device model, compare process, watchdog
  ////////////////////////////////////////////////////////////////////////////

  assign bus_rdata = dev_mem[bus_addr];

  initial begin
    for (int a = 0; a < mem_depth; a++) begin
      dev_mem[a] <= fill_byte(addr_w'(a));
    end
    forever begin
      @(posedge clk);
      if (bus_cs && bus_we) begin
        dev_mem[bus_addr] <= bus_wdata;
      end
    end
  end

  // Shadow port against the reference, only while enabled
  always @(posedge clk) begin
    if (cmp_en) begin
      cmp_checks++;
      assert (sh_data == ref_shadow(sh_idx)) else begin
        $display("MISMATCH t=%0t sh_data[%0d]: got %02h expected %02h",
                 $time, sh_idx, sh_data, ref_shadow(sh_idx));
        cmp_errs++;
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout, run still going after %0d cycles", timeout_cycles);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and check tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_low(input string name, input logic v);
    check_count++;
    assert (v == 1'b0) else begin
      $display("MISMATCH t=%0t %s: got %0b expected 0", $time, name, v);
      err_count++;
    end
  endtask

  task automatic check_latency(input string name, input int got);
    check_count++;
    assert (got == lone_latency) else begin
      $display("MISMATCH t=%0t %s: got %0d expected %0d", $time, name, got, lone_latency);
      err_count++;
    end
  endtask

  // Edges from the start sample to done
  task automatic wait_done(input logic is_wr, output int edges);
    edges = 0;
    @(negedge clk);
    while (!(is_wr ? wr_done : rd_done)) begin
      @(negedge clk);
      edges++;
    end
  endtask

  task automatic do_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    int edges;
    @(negedge clk);
    wr_addr  = a;
    wr_wdata = d;
    wr_start = 1'b1;
    wait_done(1'b1, edges);
    check_latency("wr_done latency", edges);
    // Dropped in the done cycle
    wr_start = 1'b0;
    ref_write(a, d);
  endtask

  task automatic do_read(input logic [addr_w-1:0] a, input logic [sh_idx_w-1:0] idx,
                         input logic load);
    int edges;
    @(negedge clk);
    rd_addr   = a;
    rd_sh_idx = idx;
    rd_load   = load;
    rd_start  = 1'b1;
    wait_done(1'b0, edges);
    check_latency("rd_done latency", edges);
    rd_start = 1'b0;
    ref_read(a, idx, load);
  endtask

  task automatic check_index(input logic [sh_idx_w-1:0] idx);
    @(negedge clk);
    sh_idx = idx;
    cmp_en = 1'b1;
    @(negedge clk);
    cmp_en = 1'b0;
  endtask

  task automatic sweep_shadow();
    for (int i = 0; i < sh_count; i++) begin
      @(negedge clk);
      sh_idx = sh_idx_w'(i);
      cmp_en = 1'b1;
    end
    @(negedge clk);
    cmp_en = 1'b0;
  endtask

  task automatic check_memory();
    for (int a = 0; a < mem_depth; a++) begin
      check_count++;
      assert (dev_mem[a] == ref_mem[a]) else begin
        $display("MISMATCH t=%0t dev_mem[%02h]: got %02h expected %02h",
                 $time, a, dev_mem[a], ref_mem[a]);
        err_count++;
      end
    end
  endtask

  // Start, then pull start low once the window opens
  task automatic abort_access(input logic is_wr, input logic [addr_w-1:0] a,
                              input logic [data_w-1:0] d, input logic [sh_idx_w-1:0] idx);
    @(negedge clk);
    if (is_wr) begin
      wr_addr  = a;
      wr_wdata = d;
      wr_start = 1'b1;
    end else begin
      rd_addr   = a;
      rd_sh_idx = idx;
      rd_load   = 1'b1;
      rd_start  = 1'b1;
    end
    while (!bus_cs) begin
      @(negedge clk);
    end
    rd_start = 1'b0;
    wr_start = 1'b0;
    repeat (2) @(negedge clk);
    check_count++;
    assert (!bus_cs) else begin
      $display("bus_cs still high two cycles after an abort at t=%0t", $time);
      err_count++;
    end
    // Quiet bus and no done afterwards
    repeat (8) begin
      @(negedge clk);
      check_count++;
      assert (!rd_done && !wr_done && !bus_cs) else begin
        $display("Bus or done activity after an aborted access at t=%0t", $time);
        err_count++;
      end
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    int errs;
    errs = total_errors() - errs_before;
    $display("Test %-16s %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                  e0;
    int                  j;
    logic [addr_w-1:0]   radd;
    logic [addr_w-1:0]   wadd;
    logic [data_w-1:0]   wdata;
    logic [sh_idx_w-1:0] idx;
    logic                rd_seen;
    logic                wr_seen;

    arst_n      = 1'b0;
    rd_start    = 1'b0;
    rd_addr     = '0;
    rd_sh_idx   = '0;
    rd_load     = 1'b0;
    wr_start    = 1'b0;
    wr_addr     = '0;
    wr_wdata    = '0;
    sh_idx      = '0;
    cmp_en      = 1'b0;
    lfsr_state  = lfsr_seed;
    err_count   = 0;
    check_count = 0;
    for (int a = 0; a < mem_depth; a++) begin
      ref_mem[a] = fill_byte(addr_w'(a));
    end
    for (int i = 0; i < sh_count; i++) begin
      ref_sh[i] = '0;
    end

    repeat (10) @(negedge clk);
    arst_n = 1'b1;

    // Idle outputs and cleared shadow file
    e0 = total_errors();
    @(negedge clk);
    check_low("bus_cs", bus_cs);
    check_low("bus_we", bus_we);
    check_low("rd_done", rd_done);
    check_low("wr_done", wr_done);
    sweep_shadow();
    end_test("reset", e0);

    // Random writes, then loading reads of those addresses
    e0 = total_errors();
    for (int i = 0; i < n_rand; i++) begin
      wr_addrs[i] = rand_addr();
      do_write(wr_addrs[i], rand_byte());
    end
    for (int i = 0; i < n_rand; i++) begin
      j   = int'(rand_bits(3));
      idx = rand_idx();
      do_read(wr_addrs[j], idx, 1'b1);
      check_index(idx);
    end
    sweep_shadow();
    end_test("write_read", e0);

    // Reads without load leave the shadow alone
    e0 = total_errors();
    repeat (2) begin
      idx  = rand_idx();
      radd = addr_not_holding(ref_shadow(idx));
      do_read(radd, idx, 1'b0);
    end
    sweep_shadow();
    end_test("read_no_load", e0);

    // Same cycle start, read owns the first window
    e0 = total_errors();
    for (int p = 0; p < n_pairs; p++) begin
      radd  = rand_addr();
      wadd  = (p == 0) ? radd : rand_addr();
      wdata = rand_byte();
      idx   = rand_idx();
      @(negedge clk);
      rd_addr   = radd;
      rd_sh_idx = idx;
      rd_load   = 1'b1;
      wr_addr   = wadd;
      wr_wdata  = wdata;
      rd_start  = 1'b1;
      wr_start  = 1'b1;
      while (!bus_cs) begin
        @(negedge clk);
      end
      check_count++;
      assert (bus_addr == radd) else begin
        $display("MISMATCH t=%0t bus_addr: got %02h expected %02h", $time, bus_addr, radd);
        err_count++;
      end
      rd_seen = 1'b0;
      wr_seen = 1'b0;
      while (!(rd_seen && wr_seen)) begin
        @(negedge clk);
        if (wr_done) begin
          check_count++;
          assert (rd_seen) else begin
            $display("Write finished before the read at t=%0t", $time);
            err_count++;
          end
          wr_start = 1'b0;
          wr_seen  = 1'b1;
        end
        if (rd_done) begin
          rd_start = 1'b0;
          rd_seen  = 1'b1;
        end
      end
      // Read saw the old byte on a shared address
      ref_read(radd, idx, 1'b1);
      ref_write(wadd, wdata);
      check_index(idx);
    end
    sweep_shadow();
    check_memory();
    end_test("simultaneous", e0);

    // Aborted read and write change nothing
    e0 = total_errors();
    idx  = rand_idx();
    radd = addr_not_holding(ref_shadow(idx));
    abort_access(1'b0, radd, '0, idx);
    wdata = rand_byte();
    wadd  = addr_not_holding(wdata);
    abort_access(1'b1, wadd, wdata, '0);
    sweep_shadow();
    check_memory();
    end_test("abort", e0);

    $display("Checks %0d, errors %0d", check_count + cmp_checks, total_errors());
    if (total_errors() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/rtc_access_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtc_access_props (
  input logic clk,
  input logic arst_n,
  input logic bus_cs,
  input logic gnt_rd,
  input logic gnt_wr,
  input logic rd_fin,
  input logic wr_fin,
  input logic rd_active,
  input logic rd_done,
  input logic wr_active,
  input logic wr_done
);

  import rtc_access_pkg::*;

  // Failed assertions so far
  int fail_count = 0;

  // Selected bus always has exactly one owner
  a_cs_one_owner: assert property (@(posedge clk) disable iff (!arst_n)
    bus_cs |-> (gnt_rd != gnt_wr))
    else begin
      fail_count++;
      $error("bus_cs high without a single grant");
    end

  // End of access strobes last one cycle
  a_rd_fin_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    rd_fin |=> !rd_fin)
    else begin
      fail_count++;
      $error("rd fin longer than one cycle");
    end
  a_wr_fin_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    wr_fin |=> !wr_fin)
    else begin
      fail_count++;
      $error("wr fin longer than one cycle");
    end

  // Strobe sits in the final cycle of a full window
  a_fin_last: assert property (@(posedge clk) disable iff (!arst_n)
    (rd_fin || wr_fin) |-> bus_cs && $past(bus_cs, access_cycles - 1) ##1 !bus_cs)
    else begin
      fail_count++;
      $error("fin outside the last bus_cs cycle");
    end

  // Done only after the bus is released
  a_rd_done_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !(rd_done && rd_active))
    else begin
      fail_count++;
      $error("rd done while still active");
    end
  a_wr_done_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !(wr_done && wr_active))
    else begin
      fail_count++;
      $error("wr done while still active");
    end

endmodule

bind bus_arbiter rtc_access_props u_props (
  .clk       (clk),
  .arst_n    (arst_n),
  .bus_cs    (bus_cs),
  .gnt_rd    (gnt_rd),
  .gnt_wr    (gnt_wr),
  .rd_fin    (rd.fin),
  .wr_fin    (wr.fin),
  .rd_active (rd.active),
  .rd_done   (rd.done),
  .wr_active (wr.active),
  .wr_done   (wr.done)
);

`default_nettype wire

// ==== design/rtc_access_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtc_access_top (
  input  logic                                clk,
  input  logic                                arst_n,
  // Host read request
  input  logic                                rd_start,
  input  logic [rtc_access_pkg::addr_w-1:0]   rd_addr,
  input  logic [rtc_access_pkg::sh_idx_w-1:0] rd_sh_idx,
  input  logic                                rd_load,
  output logic                                rd_done,
  // Host write request
  input  logic                                wr_start,
  input  logic [rtc_access_pkg::addr_w-1:0]   wr_addr,
  input  logic [rtc_access_pkg::data_w-1:0]   wr_wdata,
  output logic                                wr_done,
  // Shadow read port
  input  logic [rtc_access_pkg::sh_idx_w-1:0] sh_idx,
  output logic [rtc_access_pkg::data_w-1:0]   sh_data,
  // Device bus
  output logic                                bus_cs,
  output logic                                bus_we,
  output logic [rtc_access_pkg::addr_w-1:0]   bus_addr,
  output logic [rtc_access_pkg::data_w-1:0]   bus_wdata,
  input  logic [rtc_access_pkg::data_w-1:0]   bus_rdata
);

  import rtc_access_pkg::*;

  // Host fields packed as requests
  rd_payload_t rd_req;
  wr_payload_t wr_req;

  assign rd_req = '{addr: rd_addr, sh_idx: rd_sh_idx, load: rd_load};
  assign wr_req = '{addr: wr_addr, wdata: wr_wdata};

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer links
  ////////////////////////////////////////////////////////////////////////////

  seq_bus_if #(.payload_t(rd_payload_t)) rd_bus ();
  seq_bus_if #(.payload_t(wr_payload_t)) wr_bus ();

  // Read side
  access_seq #(.payload_t(rd_payload_t)) u_rd_seq (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (rd_start),
    .req    (rd_req),
    .sb     (rd_bus)
  );

  // Write side
  access_seq #(.payload_t(wr_payload_t)) u_wr_seq (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (wr_start),
    .req    (wr_req),
    .sb     (wr_bus)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Bus owner
  ////////////////////////////////////////////////////////////////////////////

  bus_arbiter u_arb (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd        (rd_bus),
    .wr        (wr_bus),
    .bus_cs    (bus_cs),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .sh_idx    (sh_idx),
    .sh_data   (sh_data)
  );

  // Completion flags out to the host
  assign rd_done = rd_bus.done;
  assign wr_done = wr_bus.done;

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  logic                                clk,
  input  logic                                arst_n,
  seq_bus_if.arb                              rd,
  seq_bus_if.arb                              wr,
  output logic                                bus_cs,
  output logic                                bus_we,
  output logic [rtc_access_pkg::addr_w-1:0]   bus_addr,
  output logic [rtc_access_pkg::data_w-1:0]   bus_wdata,
  input  logic [rtc_access_pkg::data_w-1:0]   bus_rdata,
  input  logic [rtc_access_pkg::sh_idx_w-1:0] sh_idx,
  output logic [rtc_access_pkg::data_w-1:0]   sh_data
);

  import rtc_access_pkg::*;

  // Typed views of the two payloads
  rd_payload_t rd_req;
  wr_payload_t wr_req;

  // Grant flags, at most one set
  logic gnt_rd;
  logic gnt_wr;

  // Bus window and its down-counter
  logic             cs_on;
  logic [cnt_w-1:0] cnt;

  logic held;
  logic last;

  // Shadow copies of device registers
  logic [data_w-1:0] shadow [sh_count];

  assign rd_req = rd.payload;
  assign wr_req = wr.payload;

  // Owner still wants the bus
  assign held = (gnt_rd && rd.active) || (gnt_wr && wr.active);

  // Final cycle of the window
  assign last = cs_on && (cnt == '0);

  //////////////////////////////////////////////////////////////////////////
  // Grant and access timer
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gnt_rd <= 1'b0;
      gnt_wr <= 1'b0;
      cs_on  <= 1'b0;
      cnt    <= '0;
    end else if (!held) begin
      // Bus free, read first on a tie
      gnt_rd <= rd.active;
      gnt_wr <= !rd.active && wr.active;
      cs_on  <= rd.active || wr.active;
      cnt    <= cnt_w'(access_cycles - 1);
    end else if (cs_on) begin
      if (cnt == '0) begin
        // Window over, grant kept until active drops
        cs_on <= 1'b0;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // End of access back to the owner only
  assign rd.fin = last && gnt_rd && rd.active;
  assign wr.fin = last && gnt_wr && wr.active;

  //////////////////////////////////////////////////////////////////////////
  // Device bus drive
  //////////////////////////////////////////////////////////////////////////

  assign bus_cs = cs_on;

  // Write strobe only in the commit cycle
  assign bus_we = wr.fin;

  always_comb begin
    bus_addr  = '0;
    bus_wdata = '0;
    if (cs_on && gnt_rd) begin
      bus_addr = rd_req.addr;
    end else if (cs_on && gnt_wr) begin
      bus_addr  = wr_req.addr;
      bus_wdata = wr_req.wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Shadow register file
  //////////////////////////////////////////////////////////////////////////

  // Device data captured on the read's fin edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < sh_count; i++) begin
        shadow[i] <= '0;
      end
    end else if (rd.fin && rd_req.load) begin
      shadow[rd_req.sh_idx] <= bus_rdata;
    end
  end

  // Host read port, no latency
  assign sh_data = shadow[sh_idx];

endmodule

`default_nettype wire

// ==== design/access_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_seq #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     start,
  input  payload_t req,
  seq_bus_if.seq   sb
);

  import rtc_access_pkg::*;

  seq_state_t state;
  seq_state_t next_state;

  //////////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state = seq_idle;
    case (state)
      // Wait for the host
      seq_idle: begin
        if (start) begin
          next_state = seq_access;
        end else begin
          next_state = seq_idle;
        end
      end
      // Hold the request until the arbiter ends it
      seq_access: begin
        if (sb.fin) begin
          next_state = seq_finish;
        end else begin
          next_state = seq_access;
        end
      end
      // Single done cycle
      seq_finish: begin
        next_state = seq_idle;
      end
      default: begin
        next_state = seq_idle;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // State and registered outputs
  //////////////////////////////////////////////////////////////////////////

  // Outputs follow the state of the previous cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= seq_idle;
      sb.payload <= '0;
      sb.active  <= 1'b0;
      sb.done    <= 1'b0;
    end else if (!start) begin
      // Abort, whatever the state
      state      <= seq_idle;
      sb.payload <= '0;
      sb.active  <= 1'b0;
      sb.done    <= 1'b0;
    end else begin
      state <= next_state;
      case (state)
        seq_access: begin
          sb.payload <= req;
          sb.active  <= 1'b1;
          sb.done    <= 1'b0;
        end
        seq_finish: begin
          // Release the bus, flag completion
          sb.payload <= '0;
          sb.active  <= 1'b0;
          sb.done    <= 1'b1;
        end
        default: begin
          sb.payload <= '0;
          sb.active  <= 1'b0;
          sb.done    <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/seq_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One sequencer to arbiter link
interface seq_bus_if #(
  parameter type payload_t = logic
) ();

  // Request fields, zero while idle
  payload_t payload;

  // High while the sequencer wants the bus
  logic active;

  // One cycle flag in the finish state
  logic done;

  // End of access strobe from the arbiter
  logic fin;

  // Sequencer side
  modport seq (
    output payload, active, done,
    input  fin
  );

  // Arbiter side
  modport arb (
    input  payload, active, done,
    output fin
  );

endinterface

`default_nettype wire

// ==== design/rtc_access_pkg.sv ====
`default_nettype none

package rtc_access_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and shadow geometry
  ////////////////////////////////////////////////////////////////////////////

  // Device address and data byte
  localparam int addr_w = 8;
  localparam int data_w = 8;

  // Shadow register file index and depth
  localparam int sh_idx_w = 4;
  localparam int sh_count = 1 << sh_idx_w;

  // Cycles the device bus stays selected per access
  localparam int access_cycles = 4;
  localparam int cnt_w = $clog2(access_cycles);

  // Sequencer states, same order as the original read FSM
  typedef enum logic [1:0] {
    seq_idle   = 2'd0,
    seq_access = 2'd1,
    seq_finish = 2'd2
  } seq_state_t;

  // Read request, 13 bits
  typedef struct packed {
    logic [addr_w-1:0]   addr;
    logic [sh_idx_w-1:0] sh_idx;
    logic                load;
  } rd_payload_t;

  // Write request, 16 bits
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } wr_payload_t;

endpackage

`default_nettype wire
